/* compile.f */
logic/glb_pkg.sv
logic/glb_cfg_regs.sv
logic/glb_bitstream_fetch.sv
logic/glb_bank_route.sv
logic/glb_bank_mem.sv
logic/glb_cfg_tile.sv
test/glb_cfg_tile_sva.sv
test/glb_cfg_tile_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the config tile testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -f compile.f \
    --top-module glb_cfg_tile_tb --Mdir "$build_dir" -o glb_cfg_tile_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/glb_cfg_tile_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$log"; then
    exit 1
fi
exit 0

/* test/glb_cfg_tile_tb.sv */
// config tile testbench
`timescale 1ns/1ps

module glb_cfg_tile_tb;
    import glb_pkg::*;

    localparam logic [TILE_SEL_ADDR_WIDTH-1:0] TILE_ID = 2'd1;
    localparam int TIMEOUT = 64;
    localparam int CHK_W = 80;
    localparam logic [31:0] ADDR_MASK = (32'd1 << GLB_ADDR_WIDTH) - 32'd1;
    localparam logic [31:0] SEL_MASK = (32'd1 << NUM_BANKS) - 32'd1;

    logic                         clk;
    logic                         reset;
    host_cfg_t                    host;
    logic [CONFIG_DATA_WIDTH-1:0] config_rd_data;
    logic                         config_start_pulse;
    logic                         config_done_pulse;
    bank_rd_req_t                 west_req;
    bank_rd_req_t                 east_req;
    bank_rd_rsp_t                 east_rsp = '0;
    bank_rd_rsp_t                 west_rsp;
    fbrc_cfg_t                    west_cfg;
    fbrc_cfg_t                    east_cfg;
    fbrc_cfg_t                    fbrc_cfg;
    bank_wr_t                     bank_wr;

    // east neighbour pipeline, first stage
    logic      east_v1 = 1'b0;
    glb_addr_u east_a1 = '0;

    logic [31:0] lfsr = 32'h7df7_d022;
    // copy of every word loaded into the banks
    logic [BANK_DATA_WIDTH-1:0] shadow [1 << GLB_ADDR_WIDTH];
    int cycle = 0;
    int errors;
    int tests;
    int failed;
    int test_errors;

    glb_cfg_tile dut0 (
        .clk                (clk),
        .reset              (reset),
        .glb_tile_id        (TILE_ID),
        .host               (host),
        .config_rd_data     (config_rd_data),
        .config_start_pulse (config_start_pulse),
        .config_done_pulse  (config_done_pulse),
        .west_req           (west_req),
        .east_req           (east_req),
        .east_rsp           (east_rsp),
        .west_rsp           (west_rsp),
        .west_cfg           (west_cfg),
        .east_cfg           (east_cfg),
        .fbrc_cfg           (fbrc_cfg),
        .bank_wr            (bank_wr)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // east neighbour owns every other tile, answers two cycles later
    always @(posedge clk) begin
        east_v1        <= east_req.rd_en && (east_req.addr.fields.tile != TILE_ID);
        east_a1        <= east_req.addr;
        east_rsp.valid <= east_v1;
        east_rsp.data  <= east_word(east_a1);
    end

    function automatic logic [BANK_DATA_WIDTH-1:0] east_word(input glb_addr_u a);
        return {32'hea57_0000 | 32'(a.flat), ~32'(a.flat)};
    endfunction

    function automatic glb_addr_u make_addr(input logic [TILE_SEL_ADDR_WIDTH-1:0] tile,
                                            input logic [BANK_SEL_ADDR_WIDTH-1:0] bank,
                                            input logic [BANK_ADDR_WIDTH-1:0] offset);
        glb_addr_u a;
        a.fields.tile   = tile;
        a.fields.bank   = bank;
        a.fields.offset = offset;
        return a;
    endfunction

    // x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic expect_hex(input string name, input logic [CHK_W-1:0] got,
                              input logic [CHK_W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_errors);
            failed++;
        end
        test_errors = errors;
    endtask

    task automatic host_write(input logic [GLB_CFG_REG_WIDTH-1:0] addr,
                              input logic [CONFIG_DATA_WIDTH-1:0] data);
        @(posedge clk);
        host <= '{wr: 1'b1, rd: 1'b0, addr: addr, wr_data: data};
        @(posedge clk);
        host <= '0;
    endtask

    // read-back sampled mid cycle
    task automatic host_read(input logic rd, input logic [GLB_CFG_REG_WIDTH-1:0] addr,
                             output logic [CONFIG_DATA_WIDTH-1:0] data);
        @(posedge clk);
        host <= '{wr: 1'b0, rd: rd, addr: addr, wr_data: '0};
        @(negedge clk);
        data = config_rd_data;
        @(posedge clk);
        host <= '0;
    endtask

    // 16 words into each bank of tile 1
    task automatic load_banks();
        glb_addr_u   a;
        logic [63:0] w;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int k = 0; k < 16; k++) begin
                a = make_addr(TILE_ID, b[0], k[5:0]);
                w = rand_bits(BANK_DATA_WIDTH);
                shadow[a.flat] = w;
                @(posedge clk);
                bank_wr <= '{en: 1'b1, addr: a, data: w};
            end
        end
        @(posedge clk);
        bank_wr <= '0;
    endtask

    task automatic test_regs();
        logic [CONFIG_DATA_WIDTH-1:0] rd;
        host_write(REG_START_ADDR, 32'hdead_beef);
        host_write(REG_NUM_WORDS, 32'h1234_5678);
        host_write(REG_SWITCH_SEL, 32'hffff_fffe);
        // unmapped write must not land anywhere
        host_write(2'd3, 32'hffff_ffff);
        host_read(1'b1, REG_START_ADDR, rd);
        expect_hex("config_rd_data start", CHK_W'(rd), CHK_W'(32'hdead_beef & ADDR_MASK));
        host_read(1'b1, REG_NUM_WORDS, rd);
        expect_hex("config_rd_data count", CHK_W'(rd), CHK_W'(32'h1234_5678 & ADDR_MASK));
        host_read(1'b1, REG_SWITCH_SEL, rd);
        expect_hex("config_rd_data switch", CHK_W'(rd), CHK_W'(32'hffff_fffe & SEL_MASK));
        host_read(1'b1, 2'd3, rd);
        expect_hex("config_rd_data unmapped", CHK_W'(rd), '0);
        host_read(1'b0, REG_NUM_WORDS, rd);
        expect_hex("config_rd_data rd low", CHK_W'(rd), '0);
        end_test("regs");
    endtask

    // program, start, then follow every fabric write up to done
    task automatic run_fetch(input string name, input glb_addr_u start, input int count,
                             input logic [NUM_BANKS-1:0] sel);
        int        n;
        int        t;
        int        start_cyc;
        int        last_cyc;
        glb_addr_u a;
        host_write(REG_SWITCH_SEL, 32'(sel));
        host_write(REG_START_ADDR, 32'(start.flat));
        host_write(REG_NUM_WORDS, 32'(count));
        @(posedge clk);
        config_start_pulse <= 1'b1;
        @(negedge clk);
        start_cyc = cycle;
        @(posedge clk);
        config_start_pulse <= 1'b0;
        n = 0;
        last_cyc = start_cyc;
        a = start;
        for (t = 0; t < TIMEOUT; t++) begin
            @(negedge clk);
            if (fbrc_cfg.wr) begin
                if (n >= count) begin
                    $display("unexpected fabric write after the last word in %s", name);
                    errors++;
                end else begin
                    // read n issued at start+1+n, write 2 cycles later
                    expect_hex("fbrc_cfg.wr cycle", CHK_W'(cycle - start_cyc), CHK_W'(n + 3));
                    expect_hex("fbrc_cfg.addr", CHK_W'(fbrc_cfg.addr),
                               CHK_W'(shadow[a.flat][BANK_DATA_WIDTH-1 -: CFG_ADDR_WIDTH]));
                    expect_hex("fbrc_cfg.data", CHK_W'(fbrc_cfg.data),
                               CHK_W'(shadow[a.flat][CFG_DATA_WIDTH-1:0]));
                end
                a.flat = a.flat + 1'b1;
                n++;
                last_cyc = cycle;
            end
            if (config_done_pulse) begin
                break;
            end
        end
        if (!config_done_pulse) begin
            $display("timeout waiting for config_done_pulse in %s", name);
            errors++;
        end else begin
            expect_hex("fabric write count", CHK_W'(n), CHK_W'(count));
            expect_hex("config_done_pulse cycle", CHK_W'(cycle),
                       CHK_W'((count == 0) ? start_cyc + 2 : last_cyc + 2));
        end
    endtask

    task automatic test_local_fetch();
        run_fetch("local fetch", make_addr(TILE_ID, 1'b0, 6'd2), 5, 2'b01);
        run_fetch("empty fetch", make_addr(TILE_ID, 1'b0, 6'd0), 0, 2'b01);
        end_test("local fetch");
    endtask

    // switch on bank 0, words in bank 1
    task automatic test_cascade_fetch();
        run_fetch("cascade fetch", make_addr(TILE_ID, 1'b1, 6'd9), 5, 2'b01);
        end_test("cascade fetch");
    endtask

    task automatic test_west_cfg();
        fbrc_cfg_t   w;
        logic [63:0] r;
        host_write(REG_SWITCH_SEL, 32'd0);
        for (int i = 0; i < 6; i++) begin
            r = rand_bits(BANK_DATA_WIDTH);
            // one idle slot in the middle
            w = '{wr: (i != 3), addr: r[63:32], data: r[31:0]};
            @(posedge clk);
            west_cfg <= w;
            @(negedge clk);
            expect_hex("fbrc_cfg", CHK_W'(fbrc_cfg), CHK_W'(w));
            expect_hex("east_cfg", CHK_W'(east_cfg), CHK_W'(w));
        end
        @(posedge clk);
        west_cfg <= '0;
        end_test("west pass-through");
    endtask

    // local word first, then a tile 2 word through the east model
    task automatic test_west_read();
        bank_rd_req_t q;
        glb_addr_u    a;
        int           t;
        int           req_cyc;
        host_write(REG_SWITCH_SEL, 32'd0);
        for (int i = 0; i < 2; i++) begin
            a = (i == 0) ? make_addr(TILE_ID, 1'b1, 6'd4) : make_addr(2'd2, 1'b0, 6'd4);
            q = '{rd_en: 1'b1, addr: a};
            @(posedge clk);
            west_req <= q;
            @(negedge clk);
            req_cyc = cycle;
            if (i == 1) begin
                expect_hex("east_req", CHK_W'(east_req), CHK_W'(q));
            end
            @(posedge clk);
            west_req <= '0;
            for (t = 0; t < TIMEOUT; t++) begin
                @(negedge clk);
                if (west_rsp.valid) begin
                    break;
                end
            end
            if (!west_rsp.valid) begin
                $display("timeout waiting for west_rsp.valid on address %h", a.flat);
                errors++;
            end else begin
                expect_hex("west_rsp latency", CHK_W'(cycle - req_cyc), CHK_W'(2));
                expect_hex("west_rsp.data", CHK_W'(west_rsp.data),
                           CHK_W'((i == 0) ? shadow[a.flat] : east_word(a)));
            end
        end
        end_test("west read");
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        host = '0;
        config_start_pulse = 1'b0;
        west_req = '0;
        west_cfg = '0;
        bank_wr = '0;
        errors = 0;
        tests = 0;
        failed = 0;
        test_errors = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        load_banks();
        test_regs();
        test_local_fetch();
        test_cascade_fetch();
        test_west_cfg();
        test_west_read();
        $display("tests run %0d, tests failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* test/glb_cfg_tile_sva.sv */
// config tile timing assertions
`timescale 1ns/1ps

module glb_cfg_tile_sva (
    input logic                          clk,
    input logic                          reset,
    input logic [glb_pkg::NUM_BANKS-1:0] switch_sel,
    input logic                          bank_rd_en [glb_pkg::NUM_BANKS],
    input glb_pkg::fbrc_cfg_t            west_cfg,
    input glb_pkg::fbrc_cfg_t            fbrc_cfg,
    input glb_pkg::bank_rd_rsp_t         west_rsp,
    input logic                          config_done_pulse
);
    import glb_pkg::*;

    // any local bank reading this cycle
    logic local_rd;

    always_comb begin
        local_rd = 1'b0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            local_rd = local_rd | bank_rd_en[i];
        end
    end

    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        config_done_pulse |=> !config_done_pulse)
        else $error("config_done_pulse high for more than one cycle");

    // pass-through mode with an idle west stream
    fabric_quiet: assert property (@(posedge clk) disable iff (reset)
        (switch_sel == '0 && !west_cfg.wr) |-> !fbrc_cfg.wr)
        else $error("fbrc_cfg.wr high with switch mask zero and west idle");

    local_rsp_latency: assert property (@(posedge clk) disable iff (reset)
        local_rd |-> ##2 west_rsp.valid)
        else $error("west_rsp.valid missing two cycles after a local bank read");

endmodule

bind glb_cfg_tile glb_cfg_tile_sva u_sva (
    .clk               (clk),
    .reset             (reset),
    .switch_sel        (switch_sel),
    .bank_rd_en        (bank_rd_en),
    .west_cfg          (west_cfg),
    .fbrc_cfg          (fbrc_cfg),
    .west_rsp          (west_rsp),
    .config_done_pulse (config_done_pulse)
);

/* logic/glb_cfg_tile.sv */
// global buffer config tile
`timescale 1ns/1ps

module glb_cfg_tile (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [glb_pkg::TILE_SEL_ADDR_WIDTH-1:0] glb_tile_id,
    input  glb_pkg::host_cfg_t                      host,
    output logic [glb_pkg::CONFIG_DATA_WIDTH-1:0]   config_rd_data,
    input  logic                                    config_start_pulse,
    output logic                                    config_done_pulse,
    input  glb_pkg::bank_rd_req_t                   west_req,
    output glb_pkg::bank_rd_req_t                   east_req,
    input  glb_pkg::bank_rd_rsp_t                   east_rsp,
    output glb_pkg::bank_rd_rsp_t                   west_rsp,
    input  glb_pkg::fbrc_cfg_t                      west_cfg,
    output glb_pkg::fbrc_cfg_t                      east_cfg,
    output glb_pkg::fbrc_cfg_t                      fbrc_cfg,
    input  glb_pkg::bank_wr_t                       bank_wr
);
    import glb_pkg::*;

    // register outputs
    glb_addr_u                  start_addr;
    logic [GLB_ADDR_WIDTH-1:0]  num_words;
    logic [NUM_BANKS-1:0]       switch_sel;

    // fetcher side
    bank_rd_req_t               fetch_req;
    bank_rd_rsp_t               fetch_rsp;
    fbrc_cfg_t                  fetch_cfg;
    logic                       fetch_done;
    logic                       done_q;

    // bank side
    logic                       bank_rd_en [NUM_BANKS];
    logic [BANK_ADDR_WIDTH-1:0] bank_offset [NUM_BANKS];
    logic                       bank_we [NUM_BANKS];
    logic [BANK_DATA_WIDTH-1:0] bank_wr_data [NUM_BANKS];
    logic [BANK_DATA_WIDTH-1:0] bank_rd_data [NUM_BANKS];

    glb_cfg_regs u_regs (
        .clk            (clk),
        .reset          (reset),
        .host           (host),
        .config_rd_data (config_rd_data),
        .start_addr     (start_addr),
        .num_words      (num_words),
        .switch_sel     (switch_sel)
    );

    glb_bitstream_fetch u_fetch (
        .clk         (clk),
        .reset       (reset),
        .start_pulse (config_start_pulse),
        .done_pulse  (fetch_done),
        .start_addr  (start_addr),
        .num_words   (num_words),
        .rd_req      (fetch_req),
        .rd_rsp      (fetch_rsp),
        .cfg_out     (fetch_cfg)
    );

    glb_bank_route u_route (
        .clk          (clk),
        .reset        (reset),
        .tile_id      (glb_tile_id),
        .switch_sel   (switch_sel),
        .fetch_req    (fetch_req),
        .fetch_rsp    (fetch_rsp),
        .west_req     (west_req),
        .east_req     (east_req),
        .east_rsp     (east_rsp),
        .west_rsp     (west_rsp),
        .bank_wr      (bank_wr),
        .bank_rd_en   (bank_rd_en),
        .bank_offset  (bank_offset),
        .bank_we      (bank_we),
        .bank_wr_data (bank_wr_data),
        .bank_rd_data (bank_rd_data),
        .fetch_cfg    (fetch_cfg),
        .west_cfg     (west_cfg),
        .fbrc_cfg     (fbrc_cfg),
        .east_cfg     (east_cfg)
    );

    // write offset comes straight from the load address
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        glb_bank_mem u_bank_mem (
            .clk       (clk),
            .rd_en     (bank_rd_en[i]),
            .rd_offset (bank_offset[i]),
            .rd_data   (bank_rd_data[i]),
            .we        (bank_we[i]),
            .wr_offset (bank_wr.addr.fields.offset),
            .wr_data   (bank_wr_data[i])
        );
    end

    // done retimed once at the tile boundary
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done_q <= 1'b0;
        end else begin
            done_q <= fetch_done;
        end
    end

    assign config_done_pulse = done_q;

endmodule

/* logic/glb_bank_mem.sv */
// single bank word storage
`timescale 1ns/1ps

module glb_bank_mem (
    input  logic                                clk,
    input  logic                                rd_en,
    input  logic [glb_pkg::BANK_ADDR_WIDTH-1:0] rd_offset,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] rd_data,
    input  logic                                we,
    input  logic [glb_pkg::BANK_ADDR_WIDTH-1:0] wr_offset,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] wr_data
);
    import glb_pkg::*;

    // one word per offset
    logic [BANK_DATA_WIDTH-1:0] mem [1 << BANK_ADDR_WIDTH];

    // synchronous write from the load port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_offset] <= wr_data;
        end
    end

    // registered read, holds its value when idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_offset];
        end
    end

endmodule

/* logic/glb_bank_route.sv */
// bank request and response routing
`timescale 1ns/1ps

module glb_bank_route (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [glb_pkg::TILE_SEL_ADDR_WIDTH-1:0] tile_id,
    input  logic [glb_pkg::NUM_BANKS-1:0]           switch_sel,
    input  glb_pkg::bank_rd_req_t                   fetch_req,
    output glb_pkg::bank_rd_rsp_t                   fetch_rsp,
    input  glb_pkg::bank_rd_req_t                   west_req,
    output glb_pkg::bank_rd_req_t                   east_req,
    input  glb_pkg::bank_rd_rsp_t                   east_rsp,
    output glb_pkg::bank_rd_rsp_t                   west_rsp,
    input  glb_pkg::bank_wr_t                       bank_wr,
    output logic                                    bank_rd_en [glb_pkg::NUM_BANKS],
    output logic [glb_pkg::BANK_ADDR_WIDTH-1:0]     bank_offset [glb_pkg::NUM_BANKS],
    output logic                                    bank_we [glb_pkg::NUM_BANKS],
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0]     bank_wr_data [glb_pkg::NUM_BANKS],
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0]     bank_rd_data [glb_pkg::NUM_BANKS],
    input  glb_pkg::fbrc_cfg_t                      fetch_cfg,
    input  glb_pkg::fbrc_cfg_t                      west_cfg,
    output glb_pkg::fbrc_cfg_t                      fbrc_cfg,
    output glb_pkg::fbrc_cfg_t                      east_cfg
);
    import glb_pkg::*;

    bank_rd_req_t               stage_req [NUM_BANKS];
    bank_rd_rsp_t               stage_rsp [NUM_BANKS];
    logic [NUM_BANKS-1:0]       rd_en_d1;
    logic [NUM_BANKS-1:0]       rd_en_d2;
    logic [BANK_DATA_WIDTH-1:0] rd_data_d1 [NUM_BANKS];
    fbrc_cfg_t                  cfg_sel;

    // request cascade west to east
    // a switched bank injects the fetcher request
    always_comb begin
        bank_rd_req_t carry;
        carry = west_req;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (switch_sel[i]) begin
                carry = fetch_req;
            end
            stage_req[i] = carry;
        end
    end

    // last stage bypasses east
    assign east_req = stage_req[NUM_BANKS-1];

    // per bank enables, tile and bank fields must match
    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank_rd_en[i] = stage_req[i].rd_en
                            && (stage_req[i].addr.fields.tile == tile_id)
                            && (stage_req[i].addr.fields.bank == BANK_SEL_ADDR_WIDTH'(i));
            bank_offset[i] = stage_req[i].addr.fields.offset;
            bank_we[i] = bank_wr.en
                         && (bank_wr.addr.fields.tile == tile_id)
                         && (bank_wr.addr.fields.bank == BANK_SEL_ADDR_WIDTH'(i));
            bank_wr_data[i] = bank_wr.data;
        end
    end

    // valid tracks the enable two cycles back
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_en_d1 <= '0;
            rd_en_d2 <= '0;
        end else begin
            for (int i = 0; i < NUM_BANKS; i++) begin
                rd_en_d1[i] <= bank_rd_en[i];
            end
            rd_en_d2 <= rd_en_d1;
        end
    end

    // second data stage behind the bank read register
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            rd_data_d1[i] <= bank_rd_data[i];
        end
    end

    // response chain east to west, local bank claims its slot
    always_comb begin
        bank_rd_rsp_t carry;
        carry = east_rsp;
        for (int i = NUM_BANKS - 1; i >= 0; i--) begin
            if (rd_en_d2[i]) begin
                carry.data  = rd_data_d1[i];
                carry.valid = 1'b1;
            end
            stage_rsp[i] = carry;
        end
    end

    assign west_rsp = stage_rsp[0];

    // fetcher listens at its switched bank
    always_comb begin
        fetch_rsp = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (switch_sel[i]) begin
                fetch_rsp = stage_rsp[i];
            end
        end
    end

    // own stream when fetching, else pass west through
    assign cfg_sel  = (|switch_sel) ? fetch_cfg : west_cfg;
    assign fbrc_cfg = cfg_sel;
    assign east_cfg = cfg_sel;

endmodule

/* logic/glb_bitstream_fetch.sv */
// bitstream fetch address generator
`timescale 1ns/1ps

module glb_bitstream_fetch (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               start_pulse,
    output logic                               done_pulse,
    input  glb_pkg::glb_addr_u                 start_addr,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0] num_words,
    output glb_pkg::bank_rd_req_t              rd_req,
    input  glb_pkg::bank_rd_rsp_t              rd_rsp,
    output glb_pkg::fbrc_cfg_t                 cfg_out
);
    import glb_pkg::*;

    // busy from accepted start until last response
    logic                      busy;
    logic                      issue_en;
    glb_addr_u                 issue_addr;
    logic [GLB_ADDR_WIDTH-1:0] issue_cnt;
    logic [GLB_ADDR_WIDTH-1:0] issue_next;
    logic [GLB_ADDR_WIDTH-1:0] ret_cnt;
    logic [GLB_ADDR_WIDTH-1:0] ret_next;
    logic                      done_q;

    assign issue_next = issue_cnt + 1'b1;
    assign ret_next   = ret_cnt + 1'b1;

    // issue side
    // first read goes out the cycle after start, one per cycle after that
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issue_en   <= 1'b0;
            issue_addr <= '0;
            issue_cnt  <= '0;
        end else if (start_pulse && !busy) begin
            issue_en   <= (num_words != '0);
            issue_addr <= start_addr;
            issue_cnt  <= '0;
        end else if (issue_en) begin
            // stop once num_words reads are out
            issue_en        <= (issue_next < num_words);
            issue_addr.flat <= issue_addr.flat + 1'b1;
            issue_cnt       <= issue_next;
        end
    end

    assign rd_req.rd_en = issue_en;
    assign rd_req.addr  = issue_addr;

    // return side, several reads in flight
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy    <= 1'b0;
            ret_cnt <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (!busy) begin
                if (start_pulse) begin
                    ret_cnt <= '0;
                    // empty bitstream finishes right away
                    if (num_words == '0) begin
                        done_q <= 1'b1;
                    end else begin
                        busy <= 1'b1;
                    end
                end
            end else if (rd_rsp.valid) begin
                ret_cnt <= ret_next;
                if (ret_next == num_words) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // done one cycle after the last write
    assign done_pulse = done_q;

    // upper half is the fabric address, lower half the data
    assign cfg_out.wr   = rd_rsp.valid;
    assign cfg_out.addr = rd_rsp.data[BANK_DATA_WIDTH-1 -: CFG_ADDR_WIDTH];
    assign cfg_out.data = rd_rsp.data[CFG_DATA_WIDTH-1:0];

endmodule

/* logic/glb_cfg_regs.sv */
// fetch control registers
`timescale 1ns/1ps

module glb_cfg_regs (
    input  logic                                   clk,
    input  logic                                   reset,
    input  glb_pkg::host_cfg_t                     host,
    output logic [glb_pkg::CONFIG_DATA_WIDTH-1:0]  config_rd_data,
    output glb_pkg::glb_addr_u                     start_addr,
    output logic [glb_pkg::GLB_ADDR_WIDTH-1:0]     num_words,
    output logic [glb_pkg::NUM_BANKS-1:0]          switch_sel
);
    import glb_pkg::*;

    // write decode, data truncated to each register width
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_addr <= '0;
            num_words  <= '0;
            switch_sel <= '0;
        end else if (host.wr) begin
            case (host.addr)
                REG_START_ADDR: start_addr.flat <= host.wr_data[GLB_ADDR_WIDTH-1:0];
                REG_NUM_WORDS:  num_words <= host.wr_data[GLB_ADDR_WIDTH-1:0];
                REG_SWITCH_SEL: switch_sel <= host.wr_data[NUM_BANKS-1:0];
                // unmapped slot drops the write
                default: ;
            endcase
        end
    end

    // read-back in the same cycle, zero extended
    always_comb begin
        config_rd_data = '0;
        if (host.rd) begin
            case (host.addr)
                REG_START_ADDR: config_rd_data[GLB_ADDR_WIDTH-1:0] = start_addr.flat;
                REG_NUM_WORDS:  config_rd_data[GLB_ADDR_WIDTH-1:0] = num_words;
                REG_SWITCH_SEL: config_rd_data[NUM_BANKS-1:0] = switch_sel;
                // unmapped reads as zero
                default: config_rd_data = '0;
            endcase
        end
    end

endmodule

/* logic/glb_pkg.sv */
// global buffer config tile package

package glb_pkg;

    // tile geometry
    localparam int NUM_BANKS           = 2;
    localparam int BANK_ADDR_WIDTH     = 6;
    localparam int BANK_SEL_ADDR_WIDTH = 1;
    localparam int TILE_SEL_ADDR_WIDTH = 2;
    localparam int GLB_ADDR_WIDTH      = TILE_SEL_ADDR_WIDTH + BANK_SEL_ADDR_WIDTH
                                         + BANK_ADDR_WIDTH;
    localparam int BANK_DATA_WIDTH     = 64;

    // fabric config word, upper and lower half of a bank word
    localparam int CFG_ADDR_WIDTH = 32;
    localparam int CFG_DATA_WIDTH = 32;

    // host register bus
    localparam int CONFIG_DATA_WIDTH = 32;
    localparam int GLB_CFG_REG_WIDTH = 2;

    // host register map, address 3 unmapped
    localparam logic [GLB_CFG_REG_WIDTH-1:0] REG_START_ADDR = 2'd0;
    localparam logic [GLB_CFG_REG_WIDTH-1:0] REG_NUM_WORDS  = 2'd1;
    localparam logic [GLB_CFG_REG_WIDTH-1:0] REG_SWITCH_SEL = 2'd2;

    // global word address split into tile, bank and offset
    typedef struct packed {
        logic [TILE_SEL_ADDR_WIDTH-1:0] tile;
        logic [BANK_SEL_ADDR_WIDTH-1:0] bank;
        logic [BANK_ADDR_WIDTH-1:0]     offset;
    } glb_addr_fields_t;

    // same word seen linear by the fetcher, split by the router
    typedef union packed {
        logic [GLB_ADDR_WIDTH-1:0] flat;
        glb_addr_fields_t          fields;
    } glb_addr_u;

    typedef struct packed {
        logic      rd_en;
        glb_addr_u addr;
    } bank_rd_req_t;

    typedef struct packed {
        logic [BANK_DATA_WIDTH-1:0] data;
        logic                       valid;
    } bank_rd_rsp_t;

    typedef struct packed {
        logic                      wr;
        logic [CFG_ADDR_WIDTH-1:0] addr;
        logic [CFG_DATA_WIDTH-1:0] data;
    } fbrc_cfg_t;

    typedef struct packed {
        logic                         wr;
        logic                         rd;
        logic [GLB_CFG_REG_WIDTH-1:0] addr;
        logic [CONFIG_DATA_WIDTH-1:0] wr_data;
    } host_cfg_t;

    // bitstream load into the banks
    typedef struct packed {
        logic                       en;
        glb_addr_u                  addr;
        logic [BANK_DATA_WIDTH-1:0] data;
    } bank_wr_t;

endpackage
